// ==== all.f ====
+incdir+hdl
hdl/td_pkg.sv
hdl/ts_pkg.sv
hdl/td_deserializer.sv
hdl/td_field_capture.sv
hdl/ts_step_ctrl.sv
hdl/ptp_time_keeper.sv
hdl/ptp_td_leaf.sv
verif/tb_ptp_td_leaf.sv

// ==== Bender.yml ====
package:
  name: ptp_td_leaf

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/td_pkg.sv
      - hdl/ts_pkg.sv
      - hdl/td_deserializer.sv
      - hdl/td_field_capture.sv
      - hdl/ts_step_ctrl.sv
      - hdl/ptp_time_keeper.sv
      - hdl/ptp_td_leaf.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_ptp_td_leaf.sv

// ==== verif/tb_ptp_td_leaf.sv ====
// table-driven testbench for the PTP leaf, sends serial frames and checks outputs every clock
`timescale 1ns/1ns
`default_nettype none

`include "ptp_leaf_settings.svh"

module tb_ptp_td_leaf
    import td_pkg::*;
    import ts_pkg::*;
();

    localparam int CLK_NS = 40;
    localparam int NUM_ROWS = 12;
    localparam int NUM_WORDS = 13;
    localparam int FRAME_BITS = 1 + 17 * NUM_WORDS;
    localparam int IDLE_CLKS = 300;
    localparam int TIMEOUT_NS = (15 + NUM_ROWS * (FRAME_BITS + IDLE_CLKS) + 200) * CLK_NS;

    // fields without their step flag are offsets from the predicted local time
    typedef struct packed {
        logic [3:0]               msg;
        period_t                  period;
        logic [`TS_REL_NS_W-1:0]  rel_ns;
        logic [`TS_TOD_S_W-1:0]   tod_s;
        logic [`TS_TOD_NS_W-1:0]  tod_ns;
        logic                     rel_flag;
        logic                     tod_flag;
        logic                     exp_rel;
        logic                     exp_tod;
        logic [1:0]               exp_pps;
    } row_t;

    logic    clk;
    logic    rst;
    logic    td_sdi;
    rel_ts_t output_ts_rel;
    logic    output_ts_rel_step;
    tod_ts_t output_ts_tod;
    logic    output_ts_tod_step;
    logic    output_pps;
    logic    output_pps_str;

    row_t rows [NUM_ROWS];
    logic [31:0] lfsr_state;

    // expected outputs after the latest clock edge
    rel_ts_t m_rel;
    tod_ts_t m_tod;
    period_t m_period;
    logic    m_pps, m_str, m_rel_step, m_tod_step;

    // step and period change scheduled after a frame
    int      pend_cnt;
    logic    pend_rel, pend_tod, pend_per;
    period_t pend_period;
    logic [`TS_REL_NS_W-1:0] sh_rel_ns;
    logic [`TS_TOD_S_W-1:0]  sh_tod_s;
    logic [`TS_TOD_NS_W-1:0] sh_tod_ns;
    int      pps_count;

    ptp_td_leaf dut_i (
        .clk                (clk),
        .rst                (rst),
        .td_sdi             (td_sdi),
        .output_ts_rel      (output_ts_rel),
        .output_ts_rel_step (output_ts_rel_step),
        .output_ts_tod      (output_ts_tod),
        .output_ts_tod_step (output_ts_tod_step),
        .output_pps         (output_pps),
        .output_pps_str     (output_pps_str)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        fail_now("watchdog expired, the stimulus table did not finish in time");
    end

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rel(input string name, input rel_ts_t got, input rel_ts_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_tod(input string name, input tod_ts_t got, input tod_ts_t exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            fail_now($sformatf("mismatch at %0t ns: %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            fail_now($sformatf("mismatch at %0t ns: %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    // fibonacci lfsr, taps 32 22 2 1, one step per bit
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic period_t rand_period();
        period_t p;
        p.ns = 8'd4 + 8'(rand_bits(3));
        p.fns = 16'(rand_bits(16));
        return p;
    endfunction

    function automatic rel_ts_t rel_add(input rel_ts_t t, input period_t p);
        return rel_ts_t'(t + {40'd0, p});
    endfunction

    // one clock of ToD growth with the seconds wrap
    function automatic tod_ts_t tod_add(input tod_ts_t t, input period_t p);
        logic [46:0] sum;
        tod_ts_t     r;
        sum = {1'b0, t.ns, t.fns} + {23'd0, p};
        r.fns = sum[15:0];
        if (sum[46:16] >= `NS_PER_S) begin
            r.s = t.s + 1;
            r.ns = 30'(sum[46:16] - `NS_PER_S);
        end else begin
            r.s = t.s;
            r.ns = sum[45:16];
        end
        return r;
    endfunction

    task automatic predict(input int n, output rel_ts_t r, output tod_ts_t t);
        r = m_rel;
        t = m_tod;
        repeat (n) begin
            r = rel_add(r, m_period);
            t = tod_add(t, m_period);
        end
    endtask

    task automatic set_row(input int idx, input logic [3:0] msg, input period_t period,
                           input logic [47:0] rel_ns, input logic [47:0] tod_s,
                           input logic [29:0] tod_ns, input logic rel_flag, input logic tod_flag,
                           input logic exp_rel, input logic exp_tod, input logic [1:0] exp_pps);
        rows[idx] = {msg, period, rel_ns, tod_s, tod_ns, rel_flag, tod_flag,
                     exp_rel, exp_tod, exp_pps};
    endtask

    task automatic fill_table();
        period_t p0;
        p0 = rand_period();
        set_row(0, 4'd0, p0, 48'(rand_bits(48)), 48'(rand_bits(48)), 30'(rand_bits(29)),
                1, 1, 1, 1, 0);
        set_row(1, 4'd0, p0, 0, 0, 0, 0, 0, 0, 0, 0);
        // seconds ahead of local time, a matching frame restarts the count
        set_row(2, 4'd0, p0, 0, 5, 0, 0, 0, 0, 0, 0);
        set_row(3, 4'd0, p0, 0, 5, 0, 0, 0, 0, 0, 0);
        set_row(4, 4'd0, p0, 0, 0, 0, 0, 0, 0, 0, 0);
        set_row(5, 4'd0, p0, 0, 5, 0, 0, 0, 0, 0, 0);
        set_row(6, 4'd0, p0, 0, 5, 0, 0, 0, 0, 0, 0);
        set_row(7, 4'd0, p0, 0, 5, 0, 0, 0, 0, 0, 0);
        set_row(8, 4'd0, p0, 0, 5, 0, 0, 0, 0, 1, 0);
        // one coarse step below the second
        set_row(9, 4'd0, p0, 0, 48'(rand_bits(48)), 30'd999_998_976, 0, 1, 0, 1, 1);
        set_row(10, 4'd3, rand_period(), 48'(rand_bits(48)), 48'(rand_bits(48)),
                30'(rand_bits(29)), 1, 1, 0, 0, 0);
        set_row(11, 4'd0, rand_period(), 0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    // one clock: update the expected state, compare, then drive the line
    task automatic tick(input logic sdi);
        rel_ts_t rel_base;
        tod_ts_t tod_base;
        tod_ts_t tod_next;
        @(negedge clk);
        rel_base = m_rel;
        tod_base = m_tod;
        m_rel_step = 1'b0;
        m_tod_step = 1'b0;
        if (pend_cnt != 0) begin
            pend_cnt--;
            if (pend_cnt == 0) begin
                if (pend_per) m_period = pend_period;
                m_rel_step = pend_rel;
                m_tod_step = pend_tod;
                if (pend_rel) begin
                    rel_base.ns[`TS_REL_NS_W-1:`TS_COARSE_LSB] =
                        sh_rel_ns[`TS_REL_NS_W-1:`TS_COARSE_LSB];
                end
                if (pend_tod) begin
                    tod_base.s = sh_tod_s;
                    tod_base.ns[`TS_TOD_NS_W-1:`TS_COARSE_LSB] =
                        sh_tod_ns[`TS_TOD_NS_W-1:`TS_COARSE_LSB];
                end
            end
        end
        m_rel = rel_add(rel_base, m_period);
        tod_next = tod_add(tod_base, m_period);
        m_pps = tod_next.s != tod_base.s;
        if (m_pps) begin
            m_str = 1'b1;
        end else if (tod_next.ns[`TS_TOD_NS_W-1]) begin
            m_str = 1'b0;
        end
        m_tod = tod_next;

        check_rel("output_ts_rel", output_ts_rel, m_rel);
        check_tod("output_ts_tod", output_ts_tod, m_tod);
        check_bit("output_ts_rel_step", output_ts_rel_step, m_rel_step);
        check_bit("output_ts_tod_step", output_ts_tod_step, m_tod_step);
        check_bit("output_pps", output_pps, m_pps);
        check_bit("output_pps_str", output_pps_str, m_str);
        if (output_pps) pps_count++;
        td_sdi = sdi;
    endtask

    task automatic send_row(input int idx);
        row_t        row;
        rel_ts_t     pred_rel;
        tod_ts_t     pred_tod;
        rel_ts_t     rel_a;
        logic [15:0] words [NUM_WORDS];
        logic [`TS_REL_NS_W-1:0] rel_ns;
        logic [`TS_TOD_S_W-1:0]  tod_s;
        logic [`TS_TOD_NS_W-1:0] tod_ns;
        row = rows[idx];
        pps_count = 0;
        // local time seen by the step decision, one clock after the frame end strobe
        predict(FRAME_BITS + 2, pred_rel, pred_tod);
        rel_ns = row.rel_flag ? row.rel_ns : pred_rel.ns + row.rel_ns;
        tod_s = row.tod_flag ? row.tod_s : pred_tod.s + row.tod_s;
        tod_ns = row.tod_flag ? row.tod_ns : pred_tod.ns + row.tod_ns;

        foreach (words[i]) words[i] = '0;
        words[IDX_HDR] = {12'd0, row.msg};
        words[IDX_HDR][REL_STEP_BIT] = row.rel_flag;
        words[IDX_TOD_NS_LO] = tod_ns[15:0];
        words[IDX_TOD_NS_HI] = {2'b00, tod_ns[29:16]};
        words[IDX_TOD_NS_HI][TOD_STEP_BIT] = row.tod_flag;
        words[IDX_TOD_S_0] = tod_s[15:0];
        words[IDX_TOD_S_1] = tod_s[31:16];
        words[IDX_TOD_S_2] = tod_s[47:32];
        words[IDX_REL_NS_0] = rel_ns[15:0];
        words[IDX_REL_NS_1] = rel_ns[31:16];
        words[IDX_REL_NS_2] = rel_ns[47:32];
        words[IDX_PERIOD_FNS] = row.period.fns;
        words[IDX_PERIOD_NS] = {8'd0, row.period.ns};

        tick(1'b0);
        for (int w = 0; w < NUM_WORDS; w++) begin
            for (int b = 0; b < 16; b++) tick(words[w][b]);
            tick(w == NUM_WORDS - 1);
        end

        // step lands 4 clocks after the final bit
        sh_rel_ns = rel_ns;
        sh_tod_s = tod_s;
        sh_tod_ns = tod_ns;
        pend_rel = row.exp_rel;
        pend_tod = row.exp_tod;
        pend_per = row.msg == 4'd0;
        pend_period = row.period;
        pend_cnt = 4;

        for (int i = 0; i < IDLE_CLKS; i++) begin
            tick(1'b1);
            if (i == 7) rel_a = output_ts_rel;
        end
        check_rel("output_ts_rel over idle", output_ts_rel,
                  rel_ts_t'(rel_a + (IDLE_CLKS - 8) * {40'd0, m_period}));
        check_count("output_pps pulses", pps_count, int'(row.exp_pps));
    endtask

    initial begin
        rst = 1'b1;
        td_sdi = 1'b1;
        lfsr_state = 32'h7b6b_f2c1;
        m_rel = '0;
        m_tod = '0;
        m_period = '0;
        m_pps = 1'b0;
        m_str = 1'b0;
        m_rel_step = 1'b0;
        m_tod_step = 1'b0;
        pend_cnt = 0;
        pend_rel = 1'b0;
        pend_tod = 1'b0;
        pend_per = 1'b0;
        pend_period = '0;
        pps_count = 0;
        fill_table();

        repeat (5) tick(1'b1);
        rst = 1'b0;
        repeat (10) tick(1'b1);
        for (int r = 0; r < NUM_ROWS; r++) begin
            send_row(r);
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/ptp_td_leaf.sv ====
// top level of the PTP time distribution leaf, serial line in, local timestamps and PPS out
`timescale 1ns/1ns
`default_nettype none

`include "ptp_leaf_settings.svh"

module ptp_td_leaf
    import td_pkg::*;
    import ts_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic td_sdi,
    output rel_ts_t   output_ts_rel,
    output logic      output_ts_rel_step,
    output tod_ts_t   output_ts_tod,
    output logic      output_ts_tod_step,
    output logic      output_pps,
    output logic      output_pps_str
);

    td_word_t    word;
    logic        word_valid;
    rel_ts_t     rel_shadow;
    logic        rel_valid, rel_step_req, rel_load;
    tod_ts_t     tod_shadow;
    logic        tod_valid, tod_step_req, tod_load;
    period_t     period;
    logic        period_valid;
    rel_coarse_t rel_coarse;
    tod_coarse_t tod_coarse;

    td_deserializer deser_i (
        .clk        (clk),
        .rst        (rst),
        .td_sdi     (td_sdi),
        .word       (word),
        .word_valid (word_valid)
    );

    td_field_capture capture_i (
        .clk          (clk),
        .rst          (rst),
        .word         (word),
        .word_valid   (word_valid),
        .rel_shadow   (rel_shadow),
        .rel_valid    (rel_valid),
        .rel_step_req (rel_step_req),
        .tod_shadow   (tod_shadow),
        .tod_valid    (tod_valid),
        .tod_step_req (tod_step_req),
        .period       (period),
        .period_valid (period_valid)
    );

    ts_step_ctrl #(.payload_t(rel_coarse_t)) rel_step_i (
        .clk          (clk),
        .rst          (rst),
        .shadow       (rel_coarse_t'(rel_shadow.ns[`TS_REL_NS_W-1:`TS_COARSE_LSB])),
        .shadow_valid (rel_valid),
        .step_req     (rel_step_req),
        .local_time   (rel_coarse),
        .load         (rel_load)
    );

    ts_step_ctrl #(.payload_t(tod_coarse_t)) tod_step_i (
        .clk          (clk),
        .rst          (rst),
        .shadow       (tod_coarse_t'({tod_shadow.s,
                                      tod_shadow.ns[`TS_TOD_NS_W-1:`TS_COARSE_LSB]})),
        .shadow_valid (tod_valid),
        .step_req     (tod_step_req),
        .local_time   (tod_coarse),
        .load         (tod_load)
    );

    ptp_time_keeper keeper_i (
        .clk          (clk),
        .rst          (rst),
        .period       (period),
        .period_valid (period_valid),
        .rel_shadow   (rel_shadow),
        .rel_load     (rel_load),
        .tod_shadow   (tod_shadow),
        .tod_load     (tod_load),
        .ts_rel       (output_ts_rel),
        .ts_rel_step  (output_ts_rel_step),
        .ts_tod       (output_ts_tod),
        .ts_tod_step  (output_ts_tod_step),
        .pps          (output_pps),
        .pps_str      (output_pps_str),
        .rel_coarse   (rel_coarse),
        .tod_coarse   (tod_coarse)
    );

endmodule

`default_nettype wire

// ==== hdl/ptp_time_keeper.sv ====
// local relative and ToD counters advanced by the received period, with coarse step load and PPS
`timescale 1ns/1ns
`default_nettype none

`include "ptp_leaf_settings.svh"

module ptp_time_keeper
    import ts_pkg::*;
(
    input  wire logic    clk,
    input  wire logic    rst,
    input  wire period_t period,
    input  wire logic    period_valid,
    input  wire rel_ts_t rel_shadow,
    input  wire logic    rel_load,
    input  wire tod_ts_t tod_shadow,
    input  wire logic    tod_load,
    output rel_ts_t      ts_rel,
    output logic         ts_rel_step,
    output tod_ts_t      ts_tod,
    output logic         ts_tod_step,
    output logic         pps,
    output logic         pps_str,
    output rel_coarse_t  rel_coarse,
    output tod_coarse_t  tod_coarse
);

    localparam int REL_W = $bits(rel_ts_t);
    localparam int TOD_SUM_W = `TS_TOD_NS_W + 1 + `TS_FNS_W;

    period_t                 period_q;
    rel_ts_t                 rel_base, rel_next;
    tod_ts_t                 tod_base, tod_next;
    logic [`TS_TOD_NS_W:0]   tod_ns_sum;
    logic                    tod_wrap;

    always_comb begin
        rel_base = ts_rel;
        if (rel_load) begin
            rel_base.ns[`TS_REL_NS_W-1:`TS_COARSE_LSB] =
                rel_shadow.ns[`TS_REL_NS_W-1:`TS_COARSE_LSB];
        end
        rel_next = rel_ts_t'(rel_base + REL_W'(period_q));

        tod_base = ts_tod;
        if (tod_load) begin
            tod_base.s = tod_shadow.s;
            tod_base.ns[`TS_TOD_NS_W-1:`TS_COARSE_LSB] =
                tod_shadow.ns[`TS_TOD_NS_W-1:`TS_COARSE_LSB];
        end
        // extra ns bit catches the carry past one second
        {tod_ns_sum, tod_next.fns} = {1'b0, tod_base.ns, tod_base.fns} + TOD_SUM_W'(period_q);
        tod_wrap = tod_ns_sum >= `NS_PER_S;
        tod_next.s = tod_base.s + {{(`TS_TOD_S_W-1){1'b0}}, tod_wrap};
        tod_next.ns = tod_wrap ? `TS_TOD_NS_W'(tod_ns_sum - `NS_PER_S)
                               : tod_ns_sum[`TS_TOD_NS_W-1:0];
    end

    always_ff @(posedge clk) begin
        ts_rel <= rel_next;
        ts_tod <= tod_next;
        ts_rel_step <= rel_load;
        ts_tod_step <= tod_load;
        pps <= tod_wrap;

        // stretch ends half way into the second
        if (tod_wrap) begin
            pps_str <= 1'b1;
        end else if (tod_next.ns[`TS_TOD_NS_W-1]) begin
            pps_str <= 1'b0;
        end

        if (period_valid) begin
            period_q <= period;
        end

        if (rst) begin
            ts_rel <= '0;
            ts_tod <= '0;
            ts_rel_step <= 1'b0;
            ts_tod_step <= 1'b0;
            pps <= 1'b0;
            pps_str <= 1'b0;
            period_q <= '0;
        end
    end

    assign rel_coarse = '{ns: ts_rel.ns[`TS_REL_NS_W-1:`TS_COARSE_LSB]};
    assign tod_coarse = '{s: ts_tod.s, ns: ts_tod.ns[`TS_TOD_NS_W-1:`TS_COARSE_LSB]};

endmodule

`default_nettype wire

// ==== hdl/ts_step_ctrl.sv ====
// per-payload step decision from the step flag or repeated coarse time mismatches
`timescale 1ns/1ns
`default_nettype none

`include "ptp_leaf_settings.svh"

module ts_step_ctrl #(
    parameter type payload_t = logic [7:0]
) (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire payload_t shadow,
    input  wire logic     shadow_valid,
    input  wire logic     step_req,
    input  wire payload_t local_time,
    output logic          load
);

    logic [1:0] mismatch_cnt;
    logic       mismatch;

    assign mismatch = shadow != local_time;

    always_ff @(posedge clk) begin
        load <= 1'b0;

        if (shadow_valid) begin
            if (step_req) begin
                load <= 1'b1;
                mismatch_cnt <= '0;
            end else if (mismatch) begin
                // persistent disagreement, take the master's time
                if (mismatch_cnt == `MISMATCH_LIMIT) begin
                    load <= 1'b1;
                    mismatch_cnt <= '0;
                end else begin
                    mismatch_cnt <= mismatch_cnt + 2'd1;
                end
            end else begin
                mismatch_cnt <= '0;
            end
        end

        if (rst) begin
            load <= 1'b0;
            mismatch_cnt <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/td_field_capture.sv ====
// collects word strobes into shadow timestamps and period and releases complete fields at frame end
`timescale 1ns/1ns
`default_nettype none

`include "ptp_leaf_settings.svh"

module td_field_capture
    import td_pkg::*;
    import ts_pkg::*;
(
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire td_word_t word,
    input  wire logic     word_valid,
    output rel_ts_t       rel_shadow,
    output logic          rel_valid,
    output logic          rel_step_req,
    output tod_ts_t       tod_shadow,
    output logic          tod_valid,
    output logic          tod_step_req,
    output period_t       period,
    output logic          period_valid
);

    logic [`TS_REL_NS_W-1:0] rel_ns_q;
    logic [`TS_TOD_S_W-1:0]  tod_s_q;
    logic [`TS_TOD_NS_W-1:0] tod_ns_q;
    logic [`PERIOD_NS_W-1:0] per_ns_q;
    logic [`TS_FNS_W-1:0]    per_fns_q;

    logic [15:0] hit;
    logic        frame_start;
    logic [2:0]  rel_seen, rel_seen_nxt;
    logic [4:0]  tod_seen, tod_seen_nxt;
    logic [1:0]  per_seen, per_seen_nxt;

    // one-hot index of an accepted msg 0 word
    assign hit = (word_valid && word.msg == 4'd0) ? (16'd1 << word.index) : 16'd0;
    assign frame_start = word_valid && word.index == IDX_HDR;

    assign rel_seen_nxt = (frame_start ? 3'd0 : rel_seen)
        | {hit[IDX_REL_NS_2], hit[IDX_REL_NS_1], hit[IDX_REL_NS_0]};
    assign tod_seen_nxt = (frame_start ? 5'd0 : tod_seen)
        | {hit[IDX_TOD_S_2], hit[IDX_TOD_S_1], hit[IDX_TOD_S_0],
           hit[IDX_TOD_NS_HI], hit[IDX_TOD_NS_LO]};
    assign per_seen_nxt = (frame_start ? 2'd0 : per_seen)
        | {hit[IDX_PERIOD_NS], hit[IDX_PERIOD_FNS]};

    always_ff @(posedge clk) begin
        if (hit[IDX_TOD_NS_LO]) tod_ns_q[15:0] <= word.data;
        if (hit[IDX_TOD_NS_HI]) tod_ns_q[29:16] <= word.data[13:0];
        if (hit[IDX_TOD_S_0]) tod_s_q[15:0] <= word.data;
        if (hit[IDX_TOD_S_1]) tod_s_q[31:16] <= word.data;
        if (hit[IDX_TOD_S_2]) tod_s_q[47:32] <= word.data;
        if (hit[IDX_REL_NS_0]) rel_ns_q[15:0] <= word.data;
        if (hit[IDX_REL_NS_1]) rel_ns_q[31:16] <= word.data;
        if (hit[IDX_REL_NS_2]) rel_ns_q[47:32] <= word.data;
        if (hit[IDX_PERIOD_FNS]) per_fns_q <= word.data;
        if (hit[IDX_PERIOD_NS]) per_ns_q <= word.data[`PERIOD_NS_W-1:0];
    end

    always_ff @(posedge clk) begin
        rel_valid <= 1'b0;
        tod_valid <= 1'b0;
        period_valid <= 1'b0;
        rel_seen <= rel_seen_nxt;
        tod_seen <= tod_seen_nxt;
        per_seen <= per_seen_nxt;

        // step flags held until a valid pulse has carried them
        if (rel_valid) rel_step_req <= 1'b0;
        if (tod_valid) tod_step_req <= 1'b0;
        if (hit[IDX_HDR] && word.data[REL_STEP_BIT]) rel_step_req <= 1'b1;
        if (hit[IDX_TOD_NS_HI] && word.data[TOD_STEP_BIT]) tod_step_req <= 1'b1;

        if (word_valid && word.last) begin
            rel_valid <= &rel_seen_nxt;
            tod_valid <= &tod_seen_nxt;
            period_valid <= &per_seen_nxt;
        end

        if (rst) begin
            rel_valid <= 1'b0;
            tod_valid <= 1'b0;
            period_valid <= 1'b0;
            rel_seen <= '0;
            tod_seen <= '0;
            per_seen <= '0;
            rel_step_req <= 1'b0;
            tod_step_req <= 1'b0;
        end
    end

    // protocol carries no fractional ns for the timestamps
    assign rel_shadow = '{ns: rel_ns_q, fns: '0};
    assign tod_shadow = '{s: tod_s_q, ns: tod_ns_q, fns: '0};
    assign period = '{ns: per_ns_q, fns: per_fns_q};

endmodule

`default_nettype wire

// ==== hdl/td_deserializer.sv ====
// serial time-distribution line to indexed 16-bit word strobes, one strobe per received word
`timescale 1ns/1ns
`default_nettype none

`include "ptp_leaf_settings.svh"

module td_deserializer
    import td_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic td_sdi,
    output td_word_t  word,
    output logic      word_valid
);

    logic [`TD_WORD_W-1:0] shift_q;
    logic [4:0]            bit_cnt;
    logic                  busy;
    logic [3:0]            index_q;
    logic [3:0]            msg_q;

    always_ff @(posedge clk) begin
        // data arrives lsb first
        shift_q <= {td_sdi, shift_q[`TD_WORD_W-1:1]};
        word_valid <= 1'b0;

        if (bit_cnt != 0) begin
            bit_cnt <= bit_cnt - 5'd1;
        end else begin
            busy <= 1'b0;
            if (busy) begin
                // this bit is the continue/last marker
                word.data <= shift_q;
                word.index <= index_q;
                word.msg <= (index_q == IDX_HDR) ? shift_q[3:0] : msg_q;
                word.last <= td_sdi;
                word_valid <= 1'b1;
                index_q <= index_q + 4'd1;
                if (index_q == IDX_HDR) begin
                    msg_q <= shift_q[3:0];
                end
            end
            if (!td_sdi) begin
                // start bit, or continue bit doubling as next start
                bit_cnt <= 5'd16;
                busy <= 1'b1;
            end else begin
                index_q <= IDX_HDR;
            end
        end

        if (rst) begin
            bit_cnt <= '0;
            busy <= 1'b0;
            index_q <= IDX_HDR;
            word_valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/ts_pkg.sv ====
// timestamp, coarse time and period types shared by capture, step control and timekeeper
`default_nettype none

`include "ptp_leaf_settings.svh"

package ts_pkg;

    typedef struct packed {
        logic [`PERIOD_NS_W-1:0] ns;
        logic [`TS_FNS_W-1:0]    fns;
    } period_t;

    typedef struct packed {
        logic [`TS_REL_NS_W-1:0] ns;
        logic [`TS_FNS_W-1:0]    fns;
    } rel_ts_t;

    typedef struct packed {
        logic [`TS_TOD_S_W-1:0]  s;
        logic [`TS_TOD_NS_W-1:0] ns;
        logic [`TS_FNS_W-1:0]    fns;
    } tod_ts_t;

    // ns bits from TS_COARSE_LSB upward
    typedef struct packed {
        logic [`TS_REL_NS_W-`TS_COARSE_LSB-1:0] ns;
    } rel_coarse_t;

    typedef struct packed {
        logic [`TS_TOD_S_W-1:0]                 s;
        logic [`TS_TOD_NS_W-`TS_COARSE_LSB-1:0] ns;
    } tod_coarse_t;

endpackage

`default_nettype wire

// ==== hdl/td_pkg.sv ====
// word type and word indices of the serial time-distribution protocol
`default_nettype none

`include "ptp_leaf_settings.svh"

package td_pkg;

    // one received word with its position in the frame
    typedef struct packed {
        logic [`TD_WORD_W-1:0] data;
        logic [3:0]            index;
        logic [3:0]            msg;
        logic                  last;
    } td_word_t;

    localparam logic [3:0] IDX_HDR        = 4'd0;
    localparam logic [3:0] IDX_TOD_NS_LO  = 4'd1;
    localparam logic [3:0] IDX_TOD_NS_HI  = 4'd2;
    localparam logic [3:0] IDX_TOD_S_0    = 4'd3;
    localparam logic [3:0] IDX_TOD_S_1    = 4'd4;
    localparam logic [3:0] IDX_TOD_S_2    = 4'd5;
    localparam logic [3:0] IDX_REL_NS_0   = 4'd8;
    localparam logic [3:0] IDX_REL_NS_1   = 4'd9;
    localparam logic [3:0] IDX_REL_NS_2   = 4'd10;
    localparam logic [3:0] IDX_PERIOD_FNS = 4'd11;
    localparam logic [3:0] IDX_PERIOD_NS  = 4'd12;

    // step flags inside the header and ToD ns high words
    localparam int REL_STEP_BIT = 8;
    localparam int TOD_STEP_BIT = 15;

endpackage

`default_nettype wire

// ==== hdl/ptp_leaf_settings.svh ====
// widths and constants of the PTP time distribution leaf, included by packages and RTL
`ifndef PTP_LEAF_SETTINGS_SVH
`define PTP_LEAF_SETTINGS_SVH

// protocol word width
`define TD_WORD_W 16

// timestamp field widths
`define TS_FNS_W 16
`define TS_REL_NS_W 48
`define TS_TOD_NS_W 30
`define TS_TOD_S_W 48

// integer ns part of the clock period
`define PERIOD_NS_W 8

// lowest ns bit compared and loaded on a step
`define TS_COARSE_LSB 9

`define NS_PER_S 31'd1000000000

// mismatch count at which the next mismatching frame steps local time
`define MISMATCH_LIMIT 2'd3

`endif
